// ==== Bender.yml ====
package:
  name: qracc

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - src/qraccPkg.sv
      - src/phaseTimer.sv
      - src/qraccCtrl.sv
      - src/switchMatrixDriver.sv
      - src/tsColumnArray.sv
      - src/adcDecoder.sv
      - src/qraccMacro.sv
  - target: test
    include_dirs:
      - .
    files:
      - dv/qraccTb.sv

// ==== build.f ====
+incdir+.
src/qraccPkg.sv
src/phaseTimer.sv
src/qraccCtrl.sv
src/switchMatrixDriver.sv
src/tsColumnArray.sv
src/adcDecoder.sv
src/qraccMacro.sv
dv/qraccTb.sv

// ==== dv/qraccTb.sv ====
`timescale 1ns/10ps
`include "qracc_defs.svh"

module qraccTb;

    localparam int ROWS = `QRACC_NUM_ROWS;
    localparam int COLS = `QRACC_NUM_COLS;
    localparam int ADDR_W = `QRACC_ROW_ADDR_W;
    localparam int ADC_B = `QRACC_NUM_ADC_BITS;
    localparam int SHIFT = `QRACC_ADC_SHIFTS;
    localparam int CODE_MAX = (1 << (ADC_B - 1)) - 1;
    localparam int CODE_MIN = -(1 << (ADC_B - 1));
    localparam int SUM_MAX = (1 << (ADC_B + SHIFT - 1)) - 1;
    localparam int SUM_MIN = -(1 << (ADC_B + SHIFT - 1));
    localparam int RAND_MACS = 6;
    localparam int MIXED_CMDS = 40;
    // Fill and read back, random MACs, saturation, back-pressure, mixed
    localparam int TOTAL_CMDS = 2 * ROWS + RAND_MACS + (2 * ROWS + 4) + 1 + MIXED_CMDS;
    localparam int CYCLE_LIMIT = 40 * TOTAL_CMDS + 200;

    logic CLK;
    logic arstN;
    logic cmdValid;
    qraccPkg::qraccCmd_t cmd;
    logic cmdCredit;
    logic rspValid;
    qraccPkg::qraccRsp_t rsp;
    logic rspCredit;

    logic [31:0] lcgState;
    logic [COLS-1:0] refMem [ROWS];
    qraccPkg::qraccRsp_t rspQ [$];
    int hostCredits;
    int creditTotal;
    int rspTotal;
    int cycleCount;
    int mismatchCount;
    int protocolErrors;

    qraccMacro DUT (
        .CLK, .arstN,
        .cmdValid, .cmd, .cmdCredit,
        .rspValid, .rsp, .rspCredit
    );

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    // Outputs sampled mid-cycle, away from the drive edge
    always @(negedge CLK) begin
        if (arstN) begin
            cycleCount++;
            if (cmdCredit) begin
                hostCredits++;
                creditTotal++;
            end
            if (rspValid) begin
                rspQ.push_back(rsp);
                rspTotal++;
            end
            if (cycleCount >= CYCLE_LIMIT) begin
                $display("ERROR: timeout, no progress within %0d cycles", CYCLE_LIMIT);
                $display("Something failed");
                $finish;
            end
        end
    end

    function automatic int unsigned nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState >> 8;
    endfunction

    // Ternary value of one row, both masks set reads as zero
    function automatic int ternaryOf(input logic p, input logic n);
        if (p && !n) begin
            return 1;
        end
        if (n && !p) begin
            return -1;
        end
        return 0;
    endfunction

    // Reference range, drop SHIFT bits, round half up, clamp
    function automatic int codeFromSum(input int sum);
        int q;
        if (sum > SUM_MAX) begin
            return CODE_MAX;
        end
        if (sum < SUM_MIN) begin
            return CODE_MIN;
        end
        if (SHIFT > 1) begin
            q = (sum + (1 << (SHIFT - 1))) >>> SHIFT;
        end else begin
            q = sum >>> SHIFT;
        end
        return (q > CODE_MAX) ? CODE_MAX : q;
    endfunction

    function automatic qraccPkg::qraccRsp_t modelMac(input logic [ROWS-1:0] pos,
                                                     input logic [ROWS-1:0] neg);
        qraccPkg::qraccRsp_t r;
        int sum;
        int x;
        r = '0;
        r.op = qraccPkg::OP_MAC;
        for (int j = 0; j < COLS; j++) begin
            sum = 0;
            // weight 1 takes the input as is, weight 0 negated
            for (int i = 0; i < ROWS; i++) begin
                x = ternaryOf(pos[i], neg[i]);
                sum += refMem[i][j] ? x : -x;
            end
            r.adcCodes[j] = qraccPkg::adcCode_t'(codeFromSum(sum));
        end
        return r;
    endfunction

    function automatic qraccPkg::qraccRsp_t uniformRsp(input int code);
        qraccPkg::qraccRsp_t r;
        r = '0;
        r.op = qraccPkg::OP_MAC;
        for (int j = 0; j < COLS; j++) begin
            r.adcCodes[j] = qraccPkg::adcCode_t'(code);
        end
        return r;
    endfunction

    task automatic tick();
        @(posedge CLK);
        #1;
    endtask

    task automatic checkRow(input string name, input qraccPkg::qraccRsp_t expRsp,
                            input qraccPkg::qraccRsp_t actRsp);
        if (actRsp.op != expRsp.op) begin
            $display("Mismatch %s op: expected %s, actual %s", name, expRsp.op.name(),
                     actRsp.op.name());
            mismatchCount++;
        end
        if (actRsp.rowData !== expRsp.rowData) begin
            $display("Mismatch %s rowData: expected %h, actual %h", name, expRsp.rowData,
                     actRsp.rowData);
            mismatchCount++;
        end
    endtask

    task automatic checkCodes(input string name, input qraccPkg::qraccRsp_t expRsp,
                              input qraccPkg::qraccRsp_t actRsp);
        if (actRsp.op != expRsp.op) begin
            $display("Mismatch %s op: expected %s, actual %s", name, expRsp.op.name(),
                     actRsp.op.name());
            mismatchCount++;
        end
        for (int j = 0; j < COLS; j++) begin
            if (actRsp.adcCodes[j] !== expRsp.adcCodes[j]) begin
                $display("Mismatch %s col %0d: expected %0d, actual %0d", name, j,
                         $signed(expRsp.adcCodes[j]), $signed(actRsp.adcCodes[j]));
                mismatchCount++;
            end
        end
    endtask

    task automatic checkCount(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("Mismatch %s: expected %0d, actual %0d", name, expected, actual);
            mismatchCount++;
        end
    endtask

    // Spend one host-side credit per command
    task automatic sendCmd(input qraccPkg::qraccCmd_t c);
        while (hostCredits == 0) begin
            tick();
        end
        cmd = c;
        cmdValid = 1'b1;
        hostCredits--;
        tick();
        cmdValid = 1'b0;
    endtask

    // Free one response slot after a delay and wait for the response
    task automatic collectResponse(input int delay, output qraccPkg::qraccRsp_t got);
        repeat (delay) tick();
        rspCredit = 1'b1;
        tick();
        rspCredit = 1'b0;
        while (rspQ.size() == 0) begin
            tick();
        end
        got = rspQ.pop_front();
    endtask

    task automatic writeRow(input int addr, input logic [COLS-1:0] data);
        qraccPkg::qraccCmd_t c;
        c = '0;
        c.op = qraccPkg::OP_WRITE;
        c.payload.writeView.rowAddr = ADDR_W'(addr);
        c.payload.writeView.rowData = data;
        sendCmd(c);
        refMem[addr] = data;
    endtask

    task automatic readRow(input string name, input int addr, input int delay);
        qraccPkg::qraccCmd_t c;
        qraccPkg::qraccRsp_t expRsp;
        qraccPkg::qraccRsp_t got;
        c = '0;
        c.op = qraccPkg::OP_READ;
        c.payload.writeView.rowAddr = ADDR_W'(addr);
        expRsp = '0;
        expRsp.op = qraccPkg::OP_READ;
        expRsp.rowData = refMem[addr];
        sendCmd(c);
        collectResponse(delay, got);
        checkRow(name, expRsp, got);
    endtask

    task automatic runMac(input string name, input logic [ROWS-1:0] pos,
                          input logic [ROWS-1:0] neg, input int delay,
                          input qraccPkg::qraccRsp_t expRsp);
        qraccPkg::qraccCmd_t c;
        qraccPkg::qraccRsp_t got;
        c = '0;
        c.op = qraccPkg::OP_MAC;
        c.payload.macView.posMask = pos;
        c.payload.macView.negMask = neg;
        sendCmd(c);
        collectResponse(delay, got);
        checkCodes(name, expRsp, got);
    endtask

    // +1, -1, zero, or both masks set, one quarter each
    task automatic randomMasks(output logic [ROWS-1:0] pos, output logic [ROWS-1:0] neg);
        int v;
        for (int i = 0; i < ROWS; i++) begin
            v = nextRand() % 4;
            pos[i] = (v == 0) || (v == 3);
            neg[i] = (v == 1) || (v == 3);
        end
    endtask

    task automatic testResetCredit();
        repeat (10) tick();
        checkCount("resetCredit cmdCredit", 1, creditTotal);
        checkCount("resetCredit rspValid", 0, rspTotal);
    endtask

    task automatic testFillReadBack();
        int order [ROWS];
        int k;
        int tmp;
        for (int i = 0; i < ROWS; i++) begin
            writeRow(i, COLS'(nextRand()));
            order[i] = i;
        end
        // Fisher-Yates shuffle of the read order
        for (int i = ROWS - 1; i > 0; i--) begin
            k = nextRand() % (i + 1);
            tmp = order[i];
            order[i] = order[k];
            order[k] = tmp;
        end
        for (int i = 0; i < ROWS; i++) begin
            readRow("fillReadBack", order[i], 0);
        end
    endtask

    task automatic testRandomMac();
        logic [ROWS-1:0] pos;
        logic [ROWS-1:0] neg;
        for (int n = 0; n < RAND_MACS; n++) begin
            randomMasks(pos, neg);
            runMac("randomMac", pos, neg, 0, modelMac(pos, neg));
        end
    endtask

    task automatic testSaturation();
        for (int i = 0; i < ROWS; i++) begin
            writeRow(i, '1);
        end
        runMac("satMax", '1, '0, 0, uniformRsp(CODE_MAX));
        for (int i = 0; i < ROWS; i++) begin
            writeRow(i, '0);
        end
        runMac("satMin", '1, '0, 0, uniformRsp(CODE_MIN));
        runMac("zeroInputs", '0, '0, 0, uniformRsp(0));
        runMac("bothMasks", '1, '1, 0, uniformRsp(0));
    endtask

    task automatic testBackPressure();
        logic [ROWS-1:0] pos;
        logic [ROWS-1:0] neg;
        qraccPkg::qraccCmd_t c;
        qraccPkg::qraccRsp_t expRsp;
        qraccPkg::qraccRsp_t got;
        int rspBase;
        int creditBase;
        randomMasks(pos, neg);
        expRsp = modelMac(pos, neg);
        c = '0;
        c.op = qraccPkg::OP_MAC;
        c.payload.macView.posMask = pos;
        c.payload.macView.negMask = neg;
        sendCmd(c);
        rspBase = rspTotal;
        creditBase = creditTotal;
        // No response slot granted yet, the macro must stall
        repeat (30) tick();
        if (rspTotal != rspBase || creditTotal != creditBase) begin
            $display("ERROR: backPressure saw a response or command credit with no slot free");
            protocolErrors++;
        end
        collectResponse(0, got);
        checkCodes("backPressure", expRsp, got);
        repeat (4) tick();
        checkCount("backPressure responses", rspBase + 1, rspTotal);
        checkCount("backPressure cmdCredit", creditBase + 1, creditTotal);
    endtask

    task automatic testMixed();
        logic [ROWS-1:0] pos;
        logic [ROWS-1:0] neg;
        int rspBase;
        int expectedRsps;
        int kind;
        rspBase = rspTotal;
        expectedRsps = 0;
        for (int n = 0; n < MIXED_CMDS; n++) begin
            kind = nextRand() % 3;
            if (kind == 0) begin
                writeRow(nextRand() % ROWS, COLS'(nextRand()));
            end else if (kind == 1) begin
                readRow("mixedRead", nextRand() % ROWS, nextRand() % 8);
                expectedRsps++;
            end else begin
                randomMasks(pos, neg);
                runMac("mixedMac", pos, neg, nextRand() % 8, modelMac(pos, neg));
                expectedRsps++;
            end
        end
        repeat (6) tick();
        checkCount("mixed response count", expectedRsps, rspTotal - rspBase);
        checkCount("mixed leftover responses", 0, rspQ.size());
    endtask

    initial begin
        arstN = 1'b0;
        cmdValid = 1'b0;
        cmd = '0;
        rspCredit = 1'b0;
        lcgState = 32'd94912;
        hostCredits = 0;
        creditTotal = 0;
        rspTotal = 0;
        cycleCount = 0;
        mismatchCount = 0;
        protocolErrors = 0;
        repeat (2) @(posedge CLK);
        #1;
        arstN = 1'b1;

        testResetCredit();
        testFillReadBack();
        testRandomMac();
        testSaturation();
        testBackPressure();
        testMixed();
        repeat (4) tick();

        $display("Errors: %0d mismatches, %0d protocol errors", mismatchCount, protocolErrors);
        if (mismatchCount == 0 && protocolErrors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== qracc_defs.svh ====
`ifndef QRACC_DEFS_SVH
`define QRACC_DEFS_SVH

// Array geometry
`define QRACC_NUM_ROWS 32
`define QRACC_NUM_COLS 8
`define QRACC_ROW_ADDR_W $clog2(`QRACC_NUM_ROWS)

// Flash ADC, signed code width and comparator count
`define QRACC_NUM_ADC_BITS 4
`define QRACC_NUM_COMPS ((1 << `QRACC_NUM_ADC_BITS) - 1)
// Low column-sum bits dropped by the reference range
`define QRACC_ADC_SHIFTS 2
// Column sum width, holds -ROWS..+ROWS
`define QRACC_SUM_W (`QRACC_ROW_ADDR_W + 2)

// Phase lengths in cycles
`define QRACC_PCH_CYCLES 2
`define QRACC_SENSE_CYCLES 2
`define QRACC_SETTLE_CYCLES 3
`define QRACC_PHASE_W 4
`define QRACC_CREDIT_W 4

`endif

// ==== src/adcDecoder.sv ====
`timescale 1ns/10ps
`include "qracc_defs.svh"

module adcDecoder (
    input  logic                       CLK,
    input  logic                       arstN,
    input  logic                       capRow,
    input  logic                       capCodes,
    input  logic [`QRACC_NUM_COLS-1:0] saOut,
    input  logic [`QRACC_NUM_COLS-1:0][`QRACC_NUM_COMPS-1:0] adcOut,
    input  qraccPkg::qraccOp_e         rspOp,
    output qraccPkg::qraccRsp_t        rsp
);

    localparam logic [`QRACC_NUM_ADC_BITS-1:0] OFFSET = 1 << (`QRACC_NUM_ADC_BITS - 1);

    logic [`QRACC_NUM_COLS-1:0] rowData;
    qraccPkg::adcCode_t [`QRACC_NUM_COLS-1:0] codes;
    logic [`QRACC_NUM_ADC_BITS-1:0] onesCnt [`QRACC_NUM_COLS];

    // Thermometer to count of ones
    always_comb begin
        for (int j = 0; j < `QRACC_NUM_COLS; j++) begin
            onesCnt[j] = '0;
            for (int i = 0; i < `QRACC_NUM_COMPS; i++) begin
                onesCnt[j] = onesCnt[j] + `QRACC_NUM_ADC_BITS'(adcOut[j][i]);
            end
        end
    end

    // Hold results until the next capture
    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            rowData <= '0;
            codes <= '0;
        end else begin
            if (capRow) begin
                rowData <= saOut;
            end
            if (capCodes) begin
                for (int j = 0; j < `QRACC_NUM_COLS; j++) begin
                    // Remove the half-range offset
                    codes[j] <= qraccPkg::adcCode_t'(onesCnt[j] - OFFSET);
                end
            end
        end
    end

    assign rsp = '{op: rspOp, rowData: rowData, adcCodes: codes};

endmodule

// ==== src/phaseTimer.sv ====
`timescale 1ns/10ps
`include "qracc_defs.svh"

module phaseTimer (
    input  logic                      CLK,
    input  logic                      arstN,
    input  logic                      load,
    input  logic [`QRACC_PHASE_W-1:0] length,
    output logic                      expired
);

    logic [`QRACC_PHASE_W-1:0] count;

    // Count down to zero and stay there until the next load
    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            count <= '0;
        end else if (load) begin
            count <= length;
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    // Last cycle of the phase
    // Count of one is the final cycle, so a phase lasts exactly length cycles
    assign expired = (count == `QRACC_PHASE_W'(1));

endmodule

// ==== src/qraccCtrl.sv ====
`timescale 1ns/10ps
`include "qracc_defs.svh"

module qraccCtrl (
    input  logic                      CLK,
    input  logic                      arstN,
    // Command channel
    input  logic                      cmdValid,
    input  qraccPkg::qraccCmd_t       cmd,
    output logic                      cmdCredit,
    // Response channel
    output logic                      rspValid,
    input  logic                      rspCredit,
    output qraccPkg::qraccOp_e        rspOp,
    // Phase timer
    output logic                      timerLoad,
    output logic [`QRACC_PHASE_W-1:0] timerLength,
    input  logic                      timerExpired,
    // Array side
    output qraccPkg::cmdPayload_u     payload,
    output qraccPkg::sramCtrl_t       sram,
    output qraccPkg::adcCtrl_t        adc,
    output logic                      macEn,
    output logic                      capRow,
    output logic                      capCodes
);

    qraccPkg::ctrlState_e state;
    qraccPkg::ctrlState_e stateNext;
    qraccPkg::qraccCmd_t cmdBuf;
    logic [`QRACC_CREDIT_W-1:0] rspCount;
    logic initDone;
    logic initPulse;
    logic [`QRACC_NUM_ROWS-1:0] rowOneHot;

    // One-entry command buffer
    always_ff @(posedge CLK) begin
        if ((state == qraccPkg::IDLE) && cmdValid) begin
            cmdBuf <= cmd;
        end
    end

    assign payload = cmdBuf.payload;
    assign rspOp = cmdBuf.op;
    // Word line decode, shared by write and sense
    assign rowOneHot = `QRACC_NUM_ROWS'(1) << cmdBuf.payload.writeView.rowAddr;

    // Send only while the host has a free slot
    assign rspValid = (state == qraccPkg::RESPOND) && (rspCount != '0);
    // Initial credit, write done, or response sent
    assign cmdCredit = initPulse || (state == qraccPkg::WRITE) || rspValid;

    always_comb begin
        stateNext = state;
        timerLoad = 1'b0;
        timerLength = '0;
        case (state)
            qraccPkg::IDLE: begin
                if (cmdValid) begin
                    stateNext = qraccPkg::PRECHARGE;
                    timerLoad = 1'b1;
                    timerLength = `QRACC_PHASE_W'(`QRACC_PCH_CYCLES);
                end
            end
            qraccPkg::PRECHARGE: begin
                if (timerExpired) begin
                    case (cmdBuf.op)
                        qraccPkg::OP_WRITE: stateNext = qraccPkg::WRITE;
                        qraccPkg::OP_READ: begin
                            stateNext = qraccPkg::SENSE;
                            timerLoad = 1'b1;
                            timerLength = `QRACC_PHASE_W'(`QRACC_SENSE_CYCLES);
                        end
                        default: begin
                            stateNext = qraccPkg::SETTLE;
                            timerLoad = 1'b1;
                            timerLength = `QRACC_PHASE_W'(`QRACC_SETTLE_CYCLES);
                        end
                    endcase
                end
            end
            // Single write cycle
            qraccPkg::WRITE: stateNext = qraccPkg::IDLE;
            qraccPkg::SENSE: begin
                if (timerExpired) begin
                    stateNext = qraccPkg::RESPOND;
                end
            end
            qraccPkg::SETTLE: begin
                if (timerExpired) begin
                    stateNext = qraccPkg::CAPTURE;
                end
            end
            qraccPkg::CAPTURE: stateNext = qraccPkg::RESPOND;
            // Hold here under back-pressure
            qraccPkg::RESPOND: begin
                if (rspValid) begin
                    stateNext = qraccPkg::IDLE;
                end
            end
            default: stateNext = qraccPkg::IDLE;
        endcase
    end

    // Array and ADC strobes per state
    always_comb begin
        sram = '0;
        adc = '0;
        macEn = 1'b0;
        capRow = 1'b0;
        capCodes = 1'b0;
        case (state)
            qraccPkg::PRECHARGE: sram.pch = 1'b1;
            qraccPkg::WRITE: begin
                sram.pch = 1'b1;
                sram.write = 1'b1;
                sram.wl = rowOneHot;
                sram.wrData = cmdBuf.payload.writeView.rowData;
            end
            qraccPkg::SENSE: begin
                sram.pch = 1'b1;
                sram.saen = 1'b1;
                sram.wl = rowOneHot;
                // Sample sense amps on the last sense cycle
                capRow = timerExpired;
            end
            qraccPkg::SETTLE: begin
                macEn = 1'b1;
                adc.mbl2Adc = 1'b1;
                // Comparator strobe once the bit lines have settled
                adc.ref2Adc = timerExpired;
            end
            qraccPkg::CAPTURE: capCodes = 1'b1;
            default: ;
        endcase
    end

    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            state <= qraccPkg::IDLE;
            initDone <= 1'b0;
            initPulse <= 1'b0;
        end else begin
            state <= stateNext;
            initDone <= 1'b1;
            initPulse <= !initDone;
        end
    end

    // Response credits, simultaneous grant and spend cancel out
    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            rspCount <= '0;
        end else if (rspCredit && !rspValid) begin
            rspCount <= rspCount + 1'b1;
        end else if (!rspCredit && rspValid) begin
            rspCount <= rspCount - 1'b1;
        end
    end

endmodule

// ==== src/qraccMacro.sv ====
`timescale 1ns/10ps
`include "qracc_defs.svh"

module qraccMacro (
    input  logic                CLK,
    input  logic                arstN,
    // Command channel
    input  logic                cmdValid,
    input  qraccPkg::qraccCmd_t cmd,
    output logic                cmdCredit,
    // Response channel
    output logic                rspValid,
    output qraccPkg::qraccRsp_t rsp,
    input  logic                rspCredit
);

    logic timerLoad;
    logic [`QRACC_PHASE_W-1:0] timerLength;
    logic timerExpired;
    qraccPkg::qraccOp_e rspOp;
    qraccPkg::cmdPayload_u payload;
    qraccPkg::sramCtrl_t sram;
    qraccPkg::adcCtrl_t adc;
    logic macEn;
    logic capRow;
    logic capCodes;
    qraccPkg::smSel_t pSel;
    qraccPkg::smSel_t nSel;
    logic [`QRACC_NUM_COLS-1:0] saOut;
    logic [`QRACC_NUM_COLS-1:0][`QRACC_NUM_COMPS-1:0] adcOut;

    // Sequencer and credit bookkeeping
    qraccCtrl uCtrl (
        .CLK, .arstN,
        .cmdValid, .cmd, .cmdCredit,
        .rspValid, .rspCredit, .rspOp,
        .timerLoad, .timerLength, .timerExpired,
        .payload, .sram, .adc, .macEn, .capRow, .capCodes
    );

    phaseTimer uTimer (
        .CLK, .arstN,
        .load    (timerLoad),
        .length  (timerLength),
        .expired (timerExpired)
    );

    switchMatrixDriver uSmDriver (
        .macEn, .payload, .pSel, .nSel
    );

    // Weights, bit lines and flash ADC
    tsColumnArray uArray (
        .CLK, .arstN,
        .pSel, .nSel, .sram, .adc,
        .saOut, .adcOut
    );

    adcDecoder uDecoder (
        .CLK, .arstN,
        .capRow, .capCodes,
        .saOut, .adcOut,
        .rspOp, .rsp
    );

endmodule

// ==== src/qraccPkg.sv ====
`include "qracc_defs.svh"

package qraccPkg;

    typedef enum logic [1:0] {
        OP_WRITE = 2'd0,
        OP_READ  = 2'd1,
        OP_MAC   = 2'd2
    } qraccOp_e;

    typedef logic signed [`QRACC_NUM_ADC_BITS-1:0] adcCode_t;

    // Row access view of the payload
    typedef struct packed {
        logic [`QRACC_ROW_ADDR_W-1:0] rowAddr;
        logic [`QRACC_NUM_COLS-1:0] rowData;
        logic [2*`QRACC_NUM_ROWS-`QRACC_ROW_ADDR_W-`QRACC_NUM_COLS-1:0] pad;
    } writeView_t;

    // Ternary input view, one pos and one neg bit per row
    typedef struct packed {
        logic [`QRACC_NUM_ROWS-1:0] posMask;
        logic [`QRACC_NUM_ROWS-1:0] negMask;
    } macView_t;

    typedef union packed {
        writeView_t writeView;
        macView_t macView;
    } cmdPayload_u;

    typedef struct packed {
        qraccOp_e op;
        cmdPayload_u payload;
    } qraccCmd_t;

    typedef struct packed {
        qraccOp_e op;
        logic [`QRACC_NUM_COLS-1:0] rowData;
        adcCode_t [`QRACC_NUM_COLS-1:0] adcCodes;
    } qraccRsp_t;

    // One side of the switch matrix
    typedef struct packed {
        logic [`QRACC_NUM_ROWS-1:0] vdrSel;
        logic [`QRACC_NUM_ROWS-1:0] vssSel;
        logic [`QRACC_NUM_ROWS-1:0] vrstSel;
    } smSel_t;

    typedef struct packed {
        logic [`QRACC_NUM_ROWS-1:0] wl;
        logic pch;
        logic write;
        logic saen;
        logic [`QRACC_NUM_COLS-1:0] wrData;
    } sramCtrl_t;

    typedef struct packed {
        logic mbl2Adc;
        logic ref2Adc;
    } adcCtrl_t;

    typedef enum logic [2:0] {
        IDLE,
        PRECHARGE,
        WRITE,
        SENSE,
        SETTLE,
        CAPTURE,
        RESPOND
    } ctrlState_e;

endpackage

// ==== src/switchMatrixDriver.sv ====
`timescale 1ns/10ps
`include "qracc_defs.svh"

module switchMatrixDriver (
    input  logic                  macEn,
    input  qraccPkg::cmdPayload_u payload,
    output qraccPkg::smSel_t      pSel,
    output qraccPkg::smSel_t      nSel
);

    logic [`QRACC_NUM_ROWS-1:0] plusOne;
    logic [`QRACC_NUM_ROWS-1:0] minusOne;
    logic [`QRACC_NUM_ROWS-1:0] rstRow;

    // Ternary decode per row
    // Both masks set counts as zero
    assign plusOne = {`QRACC_NUM_ROWS{macEn}} & payload.macView.posMask
        & ~payload.macView.negMask;
    assign minusOne = {`QRACC_NUM_ROWS{macEn}} & payload.macView.negMask
        & ~payload.macView.posMask;
    // Zero input or idle matrix parks the row on VRST
    assign rstRow = ~(plusOne | minusOne);

    // P side sees the input as is
    assign pSel.vdrSel = plusOne;
    assign pSel.vssSel = minusOne;
    assign pSel.vrstSel = rstRow;

    // N side sees it inverted
    assign nSel.vdrSel = minusOne;
    assign nSel.vssSel = plusOne;
    assign nSel.vrstSel = rstRow;

endmodule

// ==== src/tsColumnArray.sv ====
`timescale 1ns/10ps
`include "qracc_defs.svh"

module tsColumnArray (
    input  logic                        CLK,
    input  logic                        arstN,
    input  qraccPkg::smSel_t            pSel,
    input  qraccPkg::smSel_t            nSel,
    input  qraccPkg::sramCtrl_t         sram,
    input  qraccPkg::adcCtrl_t          adc,
    output logic [`QRACC_NUM_COLS-1:0]  saOut,
    output logic [`QRACC_NUM_COLS-1:0][`QRACC_NUM_COMPS-1:0] adcOut
);

    localparam int ADC_B = `QRACC_NUM_ADC_BITS;
    localparam int SHIFT = `QRACC_ADC_SHIFTS;
    localparam int SUM_W = `QRACC_SUM_W;
    localparam int RND_BIT = (SHIFT > 0) ? SHIFT - 1 : 0;
    // Reference range limits on the column sum
    localparam logic signed [SUM_W-1:0] SUM_MAX = (1 <<< (ADC_B + SHIFT - 1)) - 1;
    localparam logic signed [SUM_W-1:0] SUM_MIN = -(1 <<< (ADC_B + SHIFT - 1));
    localparam logic signed [ADC_B-1:0] CODE_MAX = (1 <<< (ADC_B - 1)) - 1;
    localparam logic signed [ADC_B-1:0] CODE_MIN = -(1 <<< (ADC_B - 1));

    logic [`QRACC_NUM_COLS-1:0] mem [`QRACC_NUM_ROWS];
    logic signed [SUM_W-1:0] colSum [`QRACC_NUM_COLS];
    logic signed [ADC_B:0] rawCode [`QRACC_NUM_COLS];
    logic signed [ADC_B-1:0] code [`QRACC_NUM_COLS];
    logic [ADC_B-1:0] biased [`QRACC_NUM_COLS];

    // Weight SRAM, write during precharge with the write enable
    always_ff @(posedge CLK) begin
        if (sram.pch && sram.write) begin
            for (int i = 0; i < `QRACC_NUM_ROWS; i++) begin
                if (sram.wl[i]) begin
                    mem[i] <= sram.wrData;
                end
            end
        end
    end

    // Sense amps, unregistered
    always_comb begin
        saOut = '0;
        if (sram.pch && sram.saen) begin
            for (int i = 0; i < `QRACC_NUM_ROWS; i++) begin
                if (sram.wl[i]) begin
                    saOut = saOut | mem[i];
                end
            end
        end
    end

    // Column sum on the bit line
    // Weight 1 hangs off the P side, weight 0 off the N side
    // VRST contributes nothing
    always_comb begin
        for (int j = 0; j < `QRACC_NUM_COLS; j++) begin
            colSum[j] = '0;
            for (int i = 0; i < `QRACC_NUM_ROWS; i++) begin
                if (mem[i][j]) begin
                    colSum[j] = colSum[j] + SUM_W'(pSel.vdrSel[i]) - SUM_W'(pSel.vssSel[i]);
                end else begin
                    colSum[j] = colSum[j] + SUM_W'(nSel.vdrSel[i]) - SUM_W'(nSel.vssSel[i]);
                end
            end
        end
    end

    // Flash ADC transfer
    always_comb begin
        for (int j = 0; j < `QRACC_NUM_COLS; j++) begin
            // Drop the low bits, one extra bit for the round-up
            rawCode[j] = {colSum[j][SHIFT+ADC_B-1], colSum[j][SHIFT +: ADC_B]};
            if (SHIFT > 1) begin
                rawCode[j] = rawCode[j] + {{ADC_B{1'b0}}, colSum[j][RND_BIT]};
            end
            if (colSum[j] > SUM_MAX) begin
                code[j] = CODE_MAX;
            end else if (colSum[j] < SUM_MIN) begin
                code[j] = CODE_MIN;
            end else if (rawCode[j] > CODE_MAX) begin
                // Round-up past the top code
                code[j] = CODE_MAX;
            end else begin
                code[j] = rawCode[j][ADC_B-1:0];
            end
            // Offset binary, code plus half range
            biased[j] = {~code[j][ADC_B-1], code[j][ADC_B-2:0]};
        end
    end

    // Comparator bank, latched on the reference strobe
    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            adcOut <= '0;
        end else if (adc.ref2Adc && adc.mbl2Adc) begin
            for (int j = 0; j < `QRACC_NUM_COLS; j++) begin
                for (int i = 0; i < `QRACC_NUM_COMPS; i++) begin
                    adcOut[j][i] <= (int'(biased[j]) > i);
                end
            end
        end
    end

endmodule
